// ==== Bender.yml ====
package:
  name: dcache_subsystem

sources:
  # shared package first
  - common/dcache_pkg.sv
  # design
  - dcache/dcache.sv
  - logic/wait_ram.sv
  - logic/dcache_subsystem.sv
  # simulation only
  - target: test
    files:
      - sim/dcache_props.sv
      - sim/dcache_subsystem_tb.sv

// ==== common/dcache_pkg.sv ====
// shared types, address fields and geometry constants, imported by the data cache and the RAM
package dcache_pkg;

  // basic bus types
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // cache geometry
  localparam int TAG_W         = 26;  // address bits 31:6
  localparam int IDX_W         = 3;   // address bits 5:3
  localparam int NUM_SETS      = 8;
  localparam int NUM_WAYS      = 2;
  localparam int WORDS_PER_BLK = 2;   // picked by address bit 2

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0] idx_t;

  // word address split into its cache fields
  typedef struct packed {
    tag_t       tag;
    idx_t       idx;
    logic       blkoff;  // word within the block
    logic [1:0] bytoff;  // always zero for word accesses
  } dcache_addr_t;

  // one line of the cache, 92 bits
  typedef struct packed {
    tag_t                           tag;
    word_t [WORDS_PER_BLK-1:0]      data;
    logic                           valid;
    logic                           dirty;
  } cache_entry_t;

  // cache controller states
  typedef enum logic [3:0] {
    IDLE,         // serve hits, start misses and flush
    WB_WORD0,     // write back first word of dirty victim
    WB_WORD1,
    FILL_WORD0,   // fetch first word of the missing block
    FILL_WORD1,
    FLUSH_SCAN,   // walk way 0 then way 1, one entry per cycle
    FLUSH_WORD0,  // write back a dirty entry found by the scan
    FLUSH_WORD1,
    FLUSHED       // all dirty data is in memory
  } dcache_state_t;

  // backing RAM
  localparam int RAM_WORDS   = 1024;  // indexed by address bits 11:2
  localparam int RAM_LATENCY = 2;     // wait cycles before each beat completes

endpackage

// ==== dcache/dcache.sv ====
// write-back 2-way data cache with LRU replacement, two-beat refill and a full flush on halt
module dcache (
  input  logic              CLK,
  input  logic              nRST,
  // datapath side
  input  logic              dmem_ren,
  input  logic              dmem_wen,
  input  logic              halt,
  input  dcache_pkg::addr_t dmem_addr,
  input  dcache_pkg::word_t dmem_store,
  output logic              dhit,
  output logic              flushed,
  output dcache_pkg::word_t dmem_load,
  // memory side
  input  logic              mem_wait,
  input  dcache_pkg::word_t mem_load,
  output logic              mem_ren,
  output logic              mem_wen,
  output dcache_pkg::addr_t mem_addr,
  output dcache_pkg::word_t mem_store
);
  import dcache_pkg::*;

  // storage
  cache_entry_t cache [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] lru;  // per set, the way to replace next

  // controller
  dcache_state_t state, state_nxt;
  logic [IDX_W+1:0] flush_cnt, flush_cnt_nxt;  // {way, set}, one extra bit for done

  // request decode
  dcache_addr_t q;
  logic req;
  logic hit0, hit1, hit;
  logic hit_way;

  // replacement and flush selection
  logic         victim;
  cache_entry_t victim_entry;
  logic         fl_way;
  idx_t         fl_idx;
  cache_entry_t fl_entry;

  // memory beat helpers
  logic         beat_done;
  logic         beat_word;  // which word of the block the current beat moves
  dcache_addr_t mem_fields;

  assign q   = dmem_addr;
  assign req = dmem_ren | dmem_wen;

  // tag compare on both ways of the addressed set
  assign hit0    = cache[0][q.idx].valid && (cache[0][q.idx].tag == q.tag);
  assign hit1    = cache[1][q.idx].valid && (cache[1][q.idx].tag == q.tag);
  assign hit     = hit0 | hit1;
  assign hit_way = hit1;

  assign victim       = lru[q.idx];
  assign victim_entry = cache[victim][q.idx];

  // flush walks way 0 first, so the way is the upper counter bit
  assign fl_way   = flush_cnt[IDX_W];
  assign fl_idx   = flush_cnt[IDX_W-1:0];
  assign fl_entry = cache[fl_way][fl_idx];

  assign beat_done = ~mem_wait;
  assign beat_word = (state == WB_WORD1) || (state == FILL_WORD1) || (state == FLUSH_WORD1);

  // datapath outputs
  assign dhit      = (state == IDLE) && req && hit;
  assign flushed   = (state == FLUSHED);
  assign dmem_load = cache[hit_way][q.idx].data[q.blkoff];

  // memory request for the current state
  always_comb begin
    mem_ren           = 1'b0;
    mem_wen           = 1'b0;
    mem_store         = '0;
    mem_fields        = '0;
    mem_fields.blkoff = beat_word;
    case (state)
      WB_WORD0, WB_WORD1: begin
        mem_wen        = 1'b1;
        mem_fields.tag = victim_entry.tag;  // old block address
        mem_fields.idx = q.idx;
        mem_store      = victim_entry.data[beat_word];
      end
      FILL_WORD0, FILL_WORD1: begin
        mem_ren        = 1'b1;
        mem_fields.tag = q.tag;
        mem_fields.idx = q.idx;
      end
      FLUSH_WORD0, FLUSH_WORD1: begin
        mem_wen        = 1'b1;
        mem_fields.tag = fl_entry.tag;
        mem_fields.idx = fl_idx;
        mem_store      = fl_entry.data[beat_word];
      end
      default: begin
      end
    endcase
  end

  assign mem_addr = mem_fields;

  // next state
  always_comb begin
    state_nxt     = state;
    flush_cnt_nxt = flush_cnt;
    case (state)
      IDLE: begin
        if (req && !hit) begin
          // dirty victim goes out before the refill
          state_nxt = victim_entry.dirty ? WB_WORD0 : FILL_WORD0;
        end else if (!req && halt) begin
          state_nxt     = FLUSH_SCAN;
          flush_cnt_nxt = '0;
        end
      end

      WB_WORD0: begin
        if (beat_done) state_nxt = WB_WORD1;
      end

      WB_WORD1: begin
        if (beat_done) state_nxt = FILL_WORD0;
      end

      FILL_WORD0: begin
        if (beat_done) state_nxt = FILL_WORD1;
      end

      FILL_WORD1: begin
        if (beat_done) state_nxt = IDLE;  // request hits on the next cycle
      end

      FLUSH_SCAN: begin
        if (flush_cnt == NUM_WAYS * NUM_SETS) begin
          state_nxt = FLUSHED;
        end else if (fl_entry.dirty) begin
          state_nxt = FLUSH_WORD0;
        end else begin
          flush_cnt_nxt = flush_cnt + 1'b1;  // clean entry, move on
        end
      end

      FLUSH_WORD0: begin
        if (beat_done) state_nxt = FLUSH_WORD1;
      end

      FLUSH_WORD1: begin
        if (beat_done) begin
          state_nxt     = FLUSH_SCAN;
          flush_cnt_nxt = flush_cnt + 1'b1;
        end
      end

      FLUSHED: begin
        state_nxt = FLUSHED;  // held until reset
      end

      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // state, LRU and cache array updates
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      flush_cnt <= '0;
      lru       <= '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          cache[w][s] <= '0;
        end
      end
    end else begin
      state     <= state_nxt;
      flush_cnt <= flush_cnt_nxt;
      case (state)
        IDLE: begin
          if (dhit) begin
            lru[q.idx] <= ~hit_way;  // the other way becomes LRU
            if (dmem_wen) begin
              cache[hit_way][q.idx].data[q.blkoff] <= dmem_store;
              cache[hit_way][q.idx].dirty          <= 1'b1;
            end
          end
        end

        FILL_WORD0: begin
          if (beat_done) cache[victim][q.idx].data[0] <= mem_load;
        end

        FILL_WORD1: begin
          if (beat_done) begin
            cache[victim][q.idx].data[1] <= mem_load;
            cache[victim][q.idx].tag     <= q.tag;
            cache[victim][q.idx].valid   <= 1'b1;
            cache[victim][q.idx].dirty   <= 1'b0;  // matches memory now
          end
        end

        FLUSH_WORD1: begin
          if (beat_done) cache[fl_way][fl_idx].dirty <= 1'b0;
        end

        default: begin
        end
      endcase
    end
  end

endmodule

// ==== files.f ====
common/dcache_pkg.sv
dcache/dcache.sv
logic/wait_ram.sv
logic/dcache_subsystem.sv
sim/dcache_props.sv
sim/dcache_subsystem_tb.sv

// ==== logic/dcache_subsystem.sv ====
// top level joining the data cache to its wait-state RAM, exposes the datapath port
module dcache_subsystem (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              dmem_ren,
  input  logic              dmem_wen,
  input  logic              halt,
  input  dcache_pkg::addr_t dmem_addr,
  input  dcache_pkg::word_t dmem_store,
  output logic              dhit,
  output logic              flushed,
  output dcache_pkg::word_t dmem_load
);
  import dcache_pkg::*;

  // cache to RAM
  logic  mem_ren;
  logic  mem_wen;
  addr_t mem_addr;
  word_t mem_store;
  logic  mem_wait;
  word_t mem_load;

  dcache u_dcache (
    .CLK        (CLK),
    .nRST       (nRST),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .halt       (halt),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .dhit       (dhit),
    .flushed    (flushed),
    .dmem_load  (dmem_load),
    .mem_wait   (mem_wait),
    .mem_load   (mem_load),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_addr   (mem_addr),
    .mem_store  (mem_store)
  );

  wait_ram u_ram (
    .CLK         (CLK),
    .nRST        (nRST),
    .ren         (mem_ren),
    .wen         (mem_wen),
    .addr        (mem_addr),
    .store       (mem_store),
    .wait_n_busy (mem_wait),
    .load        (mem_load)
  );

endmodule

// ==== logic/wait_ram.sv ====
// word-wide backing RAM that stalls every access for a fixed number of wait cycles
module wait_ram (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              ren,
  input  logic              wen,
  input  dcache_pkg::addr_t addr,
  input  dcache_pkg::word_t store,
  output logic              wait_n_busy,
  output dcache_pkg::word_t load
);
  import dcache_pkg::*;

  word_t mem [RAM_WORDS];

  logic [$clog2(RAM_WORDS)-1:0]     word_idx;
  logic [$clog2(RAM_LATENCY+1)-1:0] wait_cnt;  // cycles spent on the current beat
  logic                             req;
  logic                             beat_done;

  assign req       = ren | wen;
  assign word_idx  = addr[$clog2(RAM_WORDS)+1:2];  // word address, byte bits dropped
  assign beat_done = req && (wait_cnt == $bits(wait_cnt)'(RAM_LATENCY));

  // busy while a request is still counting its wait cycles
  assign wait_n_busy = req && !beat_done;

  // contents start at zero and survive nRST
  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // wait counter, restarts after every completed beat
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!req || beat_done) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // write lands in the completing cycle
  always @(posedge CLK) begin
    if (wen && beat_done) begin
      mem[word_idx] <= store;
    end
  end

  assign load = mem[word_idx];  // sampled by the cache when wait drops

endmodule

// ==== sim/dcache_props.sv ====
// concurrent checks on the cache memory handshake and datapath flags, bound into every dcache
module dcache_props (
  input logic              CLK,
  input logic              nRST,
  input logic              mem_ren,
  input logic              mem_wen,
  input logic              mem_wait,
  input dcache_pkg::addr_t mem_addr,
  input logic              dhit,
  input logic              flushed
);

  int fail_count = 0;  // picked up by the testbench summary

  // one memory operation at a time
  a_no_read_write: assert property (@(posedge CLK) disable iff (!nRST)
    !(mem_ren && mem_wen))
    else begin
      fail_count++;
      $error("mem_ren and mem_wen high in the same cycle");
    end

  // address held while the RAM is still waiting
  a_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
    mem_wait |=> $stable(mem_addr))
    else begin
      fail_count++;
      $error("mem_addr changed while mem_wait was high");
    end

  a_no_hit_flushed: assert property (@(posedge CLK) disable iff (!nRST)
    !(dhit && flushed))
    else begin
      fail_count++;
      $error("dhit raised after the cache was flushed");
    end

endmodule

bind dcache dcache_props u_props (
  .CLK      (CLK),
  .nRST     (nRST),
  .mem_ren  (mem_ren),
  .mem_wen  (mem_wen),
  .mem_wait (mem_wait),
  .mem_addr (mem_addr),
  .dhit     (dhit),
  .flushed  (flushed)
);

// ==== sim/dcache_subsystem_tb.sv ====
// table-driven testbench for the data cache subsystem, run as the simulation top
module dcache_subsystem_tb;
  import dcache_pkg::*;

  localparam int RESET_CYCLES    = 8;
  localparam int MAX_TESTS       = 40;
  localparam int CYCLES_PER_TEST = 2 + 4 * (RAM_LATENCY + 1) + 1;  // scan, 4 beats, idle hit

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_HALT, OP_RESET} op_t;

  logic  CLK;
  logic  nRST;
  logic  dmem_ren;
  logic  dmem_wen;
  logic  halt;
  addr_t dmem_addr;
  word_t dmem_store;
  logic  dhit;
  logic  flushed;
  word_t dmem_load;

  // test table
  string t_name    [MAX_TESTS];
  op_t   t_op      [MAX_TESTS];
  addr_t t_addr    [MAX_TESTS];
  word_t t_data    [MAX_TESTS];
  word_t t_exp     [MAX_TESTS];
  logic  t_hit_now [MAX_TESTS];  // must hit in the request cycle
  int    num_tests;
  logic  table_ready;

  word_t shadow [RAM_WORDS];  // last value written per word, zero otherwise
  word_t rng_state;
  int    err_cnt;
  int    cycle_cnt;
  int    cycle_limit;

  dcache_subsystem u_dcache_subsystem (
    .CLK        (CLK),
    .nRST       (nRST),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .halt       (halt),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .dhit       (dhit),
    .flushed    (flushed),
    .dmem_load  (dmem_load)
  );

  always #5 CLK = ~CLK;

  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic addr_t make_addr(input int tag, input int idx, input logic blkoff);
    dcache_addr_t a;
    a        = '0;
    a.tag    = tag_t'(tag);
    a.idx    = idx_t'(idx);
    a.blkoff = blkoff;
    return a;
  endfunction

  task automatic add_entry(input string name, input op_t op, input addr_t addr,
                           input word_t data, input word_t exp, input logic hit_now);
    t_name[num_tests]    = name;
    t_op[num_tests]      = op;
    t_addr[num_tests]    = addr;
    t_data[num_tests]    = data;
    t_exp[num_tests]     = exp;
    t_hit_now[num_tests] = hit_now;
    num_tests++;
  endtask

  task automatic add_write(input string name, input addr_t addr);
    word_t data;
    data = next_rand();
    shadow[addr[11:2]] = data;
    add_entry(name, OP_WRITE, addr, data, '0, 1'b0);
  endtask

  task automatic add_read(input string name, input addr_t addr, input logic hit_now);
    add_entry(name, OP_READ, addr, '0, shadow[addr[11:2]], hit_now);
  endtask

  task automatic build_table();
    add_read("cold_read", make_addr(1, 2, 0), 1'b0);
    add_read("cold_read_again", make_addr(1, 2, 0), 1'b1);
    add_write("write_word", make_addr(1, 3, 0));
    add_read("read_word", make_addr(1, 3, 0), 1'b1);
    add_read("read_partner", make_addr(1, 3, 1), 1'b1);
    // three tags in set 5, the third evicts a dirty block
    add_write("evict_write_t2", make_addr(2, 5, 0));
    add_write("evict_write_t3", make_addr(3, 5, 1));
    add_write("evict_write_t4", make_addr(4, 5, 0));
    add_read("evict_read_t2", make_addr(2, 5, 0), 1'b0);
    add_read("evict_read_t3", make_addr(3, 5, 1), 1'b0);
    add_read("evict_read_t4", make_addr(4, 5, 0), 1'b0);
    // lru order in set 6
    add_write("lru_write_a", make_addr(5, 6, 1));
    add_read("lru_read_a", make_addr(5, 6, 1), 1'b1);
    add_write("lru_write_b", make_addr(6, 6, 0));
    add_write("lru_write_c", make_addr(7, 6, 1));
    add_read("lru_hit_b", make_addr(6, 6, 0), 1'b1);  // c replaced a, b still cached
    add_read("lru_reread_a", make_addr(5, 6, 1), 1'b0);
    add_read("lru_read_b", make_addr(6, 6, 0), 1'b0);
    // flush, then check the RAM copy after reset
    add_write("flush_write_s0", make_addr(8, 0, 0));
    add_write("flush_write_s1", make_addr(8, 1, 1));
    add_write("flush_write_s7", make_addr(9, 7, 0));
    add_write("flush_write_s4", make_addr(9, 4, 1));
    add_entry("halt_flush", OP_HALT, make_addr(8, 0, 0), '0, '0, 1'b0);
    add_entry("reset_pulse", OP_RESET, '0, '0, '0, 1'b0);
    add_read("persist_s0", make_addr(8, 0, 0), 1'b0);
    add_read("persist_s1", make_addr(8, 1, 1), 1'b0);
    add_read("persist_s7", make_addr(9, 7, 0), 1'b0);
    add_read("persist_s4", make_addr(9, 4, 1), 1'b0);
    add_read("persist_t2", make_addr(2, 5, 0), 1'b0);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  // entered and left 1 time unit after a rising edge
  task automatic run_test(input int i);
    logic first_hit;
    int   errs_before;
    errs_before = err_cnt;
    case (t_op[i])
      OP_READ, OP_WRITE: begin
        dmem_addr  = t_addr[i];
        dmem_store = t_data[i];
        dmem_ren   = (t_op[i] == OP_READ);
        dmem_wen   = (t_op[i] == OP_WRITE);
        @(negedge CLK);
        first_hit = dhit;
        while (dhit !== 1'b1) @(negedge CLK);
        if (t_op[i] == OP_READ) check_word(t_name[i], t_exp[i], dmem_load);
        if (t_hit_now[i]) check_flag({t_name[i], " first cycle hit"}, 1'b1, first_hit);
        @(posedge CLK);
        #1;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
      end
      OP_HALT: begin
        halt = 1'b1;
        @(negedge CLK);
        while (flushed !== 1'b1) @(negedge CLK);
        @(posedge CLK);
        #1;
        dmem_addr = t_addr[i];  // block still cached, would hit before the flush
        dmem_ren  = 1'b1;
        repeat (3) begin  // flushed must hold
          @(negedge CLK);
          check_flag({t_name[i], " flushed held"}, 1'b1, flushed);
          check_flag({t_name[i], " dhit low"}, 1'b0, dhit);
        end
        @(posedge CLK);
        #1;
        dmem_ren = 1'b0;
      end
      default: begin  // reset pulse, RAM keeps its contents
        halt = 1'b0;
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        check_flag({t_name[i], " flushed cleared"}, 1'b0, flushed);
        @(posedge CLK);
        #1;
      end
    endcase
    if (err_cnt == errs_before) $display("test %0d %s ok", i, t_name[i]);
    else $display("test %0d %s had %0d errors", i, t_name[i], err_cnt - errs_before);
  endtask

  initial begin
    int assert_fails;
    CLK         = 1'b0;
    nRST        = 1'b0;
    dmem_ren    = 1'b0;
    dmem_wen    = 1'b0;
    halt        = 1'b0;
    dmem_addr   = '0;
    dmem_store  = '0;
    err_cnt     = 0;
    num_tests   = 0;
    rng_state   = 32'd69992;
    table_ready = 1'b0;
    for (int k = 0; k < RAM_WORDS; k++) shadow[k] = '0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(posedge CLK);
    #1;
    for (int i = 0; i < num_tests; i++) run_test(i);
    assert_fails = u_dcache_subsystem.u_dcache.u_props.fail_count;
    $display("%0d tests, %0d check errors, %0d assertion failures",
             num_tests, err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // run limit sized from the table length
  initial begin
    wait (table_ready);
    cycle_limit = 2 * (num_tests * CYCLES_PER_TEST + 32) + RESET_CYCLES + 4;
    cycle_cnt   = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("timeout: the cache did not answer within %0d cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

endmodule
